// ==== rtl/mvau_pkg.sv ====
`default_nettype none

package mvau_pkg;

   // Matrix and folding sizes
   localparam int MATRIX_W = 16;                           // Columns, one vector length
   localparam int MATRIX_H = 8;                            // Rows, one result per row
   localparam int SIMD     = 4;                            // Activations per input word
   localparam int PE       = 2;                            // Rows in parallel
   localparam int SF       = MATRIX_W / SIMD;              // Input words per vector
   localparam int NF       = MATRIX_H / PE;                // Passes per vector
   localparam int SF_T     = (SF > 1) ? $clog2(SF) : 1;    // sf counter width
   localparam int NF_T     = (NF > 1) ? $clog2(NF) : 1;    // nf counter width
   localparam int TILES    = NF * SF;                      // Tiles held per lane
   localparam int TILE_T   = (TILES > 1) ? $clog2(TILES) : 1;
   localparam int PE_T     = (PE > 1) ? $clog2(PE) : 1;    // Lane select width

   // Data widths
   localparam int TSRC_I   = 4;                            // Activation bits
   localparam int TW       = 4;                            // Weight bits
   localparam int TACC     = 16;                           // Accumulator bits
   localparam int TDST_I   = 8;                            // Result bits

   typedef logic signed [TSRC_I-1:0]      act_t;
   typedef logic signed [TW-1:0]          wgt_t;
   typedef logic [SIMD*TSRC_I-1:0]        in_word_t;       // Element 0 in low bits
   typedef logic [SIMD*TW-1:0]            wgt_tile_t;      // Same order as in_word_t
   typedef logic signed [TACC-1:0]        acc_t;
   typedef logic signed [TDST_I-1:0]      res_t;
   typedef logic [PE*TDST_I-1:0]          out_word_t;      // Lane 0 in low bits
   typedef logic [SF_T-1:0]               sf_cnt_t;
   typedef logic [NF_T-1:0]               nf_cnt_t;
   typedef logic [TILE_T-1:0]             tile_addr_t;     // nf*SF + sf
   typedef logic [PE_T-1:0]               pe_idx_t;

   // Clip limits of res_t, held at accumulator width
   localparam acc_t RES_MAX = acc_t'((2 ** (TDST_I - 1)) - 1);
   localparam acc_t RES_MIN = acc_t'(-(2 ** (TDST_I - 1)));

   // Fold controller states
   typedef enum logic [1:0] {
      IDLE,                                                // Waiting for a vector
      FIRST_PASS,                                          // Live words, buffer filling
      REPLAY                                               // Passes 1..NF-1 from buffer
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/mvau_inp_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Holds one input vector, SF words deep.
// Filled during pass 0 and read back for every later pass.
module mvau_inp_buffer
   import mvau_pkg::*;
(
   input  logic     clk,
   input  logic     wen,                 // Write strobe, pass 0
   input  logic     ren,                 // Read strobe, replay passes
   input  sf_cnt_t  addr,                // Word index inside the vector
   input  in_word_t wdata,               // Live input word
   output in_word_t rdata                // Valid one cycle after ren
);

   in_word_t mem [SF];                   // Vector storage

   // Write port
   always_ff @(posedge clk) begin
      if (wen) begin
         mem[addr] <= wdata;             // Capture live word
      end
   end

   // Registered read, lines up with weight memory latency
   always_ff @(posedge clk) begin
      if (ren) begin
         rdata <= mem[addr];             // Replay word
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mvau_control.sv ====
`timescale 1ns/1ps
`default_nettype none

// Fold controller
// Pass 0 follows in_valid, passes 1..NF-1 replay the buffer one tile per cycle.
module mvau_control
   import mvau_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       in_valid,          // Input word strobe
   input  in_word_t   in_data,
   output logic       buf_wen,           // Buffer write, pass 0
   output logic       buf_ren,           // Buffer read, replay
   output sf_cnt_t    buf_addr,
   input  in_word_t   buf_data,          // Buffer read data, one cycle late
   output tile_addr_t tile_addr,         // Weight memory read address
   output in_word_t   act_data,          // Activations at PE inputs
   output logic       tile_valid,        // Flags aligned to act_data
   output logic       tile_first,
   output logic       tile_last,
   output logic       busy               // Source must wait while high
);

   ctrl_state_t state;
   sf_cnt_t     sf_cnt;                  // Word index in the vector
   nf_cnt_t     nf_cnt;                  // Pass index
   logic        issue_live;              // Tile from live input
   logic        issue_rep;               // Tile from buffer
   logic        issue;
   logic        sf_wrap;                 // Last word of a pass
   logic        nf_wrap;                 // Last pass of a vector
   logic        live_sel;                // Select for act_data mux
   in_word_t    in_data_q;               // Live word, one cycle late

   assign issue_live = in_valid && (state != REPLAY);
   assign issue_rep  = (state == REPLAY);  // One tile every cycle
   assign issue      = issue_live || issue_rep;
   assign sf_wrap    = (sf_cnt == sf_cnt_t'(SF - 1));
   assign nf_wrap    = (nf_cnt == nf_cnt_t'(NF - 1));

   assign buf_wen   = issue_live;
   assign buf_ren   = issue_rep;
   assign buf_addr  = sf_cnt;
   assign tile_addr = tile_addr_t'(nf_cnt * SF + sf_cnt);  // Row block nf, column sf
   assign busy      = (state != IDLE);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= IDLE;
         sf_cnt     <= '0;
         nf_cnt     <= '0;
         tile_valid <= 1'b0;
         tile_first <= 1'b0;
         tile_last  <= 1'b0;
         live_sel   <= 1'b0;
      end else begin
         tile_valid <= issue;                        // Flags trail issue by one
         tile_first <= issue && (sf_cnt == '0);
         tile_last  <= issue && sf_wrap;
         live_sel   <= issue_live;
         if (issue) begin
            if (sf_wrap) begin
               sf_cnt <= '0;
               if (nf_wrap) begin
                  nf_cnt <= '0;
                  state  <= IDLE;                    // Vector done
               end else begin
                  nf_cnt <= nf_cnt + 1'b1;
                  state  <= REPLAY;                  // Next pass from buffer
               end
            end else begin
               sf_cnt <= sf_cnt + 1'b1;
               if (state == IDLE) begin
                  state <= FIRST_PASS;               // First word seen
               end
            end
         end
      end
   end

   // Matches the buffer read latency
   always_ff @(posedge clk) begin
      if (issue_live) begin
         in_data_q <= in_data;
      end
   end

   assign act_data = live_sel ? in_data_q : buf_data;  // Live in pass 0, else buffered

endmodule

`default_nettype wire

// ==== rtl/mvau_weight_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// Weight storage, one bank per PE lane.
// Row nf*PE+p sits in bank p at tiles nf*SF .. nf*SF+SF-1.
module mvau_weight_mem
   import mvau_pkg::*;
(
   input  logic       clk,
   input  logic       wgt_wen,           // Load strobe
   input  pe_idx_t    wgt_pe,            // Lane to load
   input  tile_addr_t wgt_addr,          // Tile to load
   input  wgt_tile_t  wgt_data,
   input  tile_addr_t tile_addr,         // Read address from controller
   output wgt_tile_t  wgt_tile [PE]      // One tile per lane, registered
);

   for (genvar p = 0; p < PE; p++) begin : bank

      wgt_tile_t mem [TILES];            // This lane's tiles
      logic      sel;                    // Lane hit on the write port

      assign sel = wgt_wen && (wgt_pe == pe_idx_t'(p));

      // Write port
      always_ff @(posedge clk) begin
         if (sel) begin
            mem[wgt_addr] <= wgt_data;
         end
      end

      // Read every cycle
      always_ff @(posedge clk) begin
         wgt_tile[p] <= mem[tile_addr];  // Ready with act_data
      end

   end

endmodule

`default_nettype wire

// ==== rtl/mvau_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

// One PE lane
// SIMD multiplies, adder tree, accumulation over SF tiles.
module mvau_pe
   import mvau_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      tile_valid,         // Tile present this cycle
   input  logic      tile_first,         // First tile of a row
   input  logic      tile_last,          // Last tile of a row
   input  in_word_t  act_data,
   input  wgt_tile_t wgt_tile,
   output acc_t      acc,                // Row sum
   output logic      acc_valid           // One cycle, acc is final
);

   act_t act_e [SIMD];                   // Unpacked activations
   wgt_t wgt_e [SIMD];                   // Unpacked weights
   acc_t prod_q [SIMD];                  // Registered products
   logic valid_q;
   logic first_q;
   logic last_q;
   acc_t tile_sum;

   // Pairwise reduction, leaves at SIMD-1 .. 2*SIMD-2
   function automatic acc_t tree_sum(input acc_t v [SIMD]);
      acc_t node [2*SIMD-1];
      for (int i = 0; i < SIMD; i++) begin
         node[SIMD-1+i] = v[i];
      end
      for (int i = SIMD - 2; i >= 0; i--) begin
         node[i] = node[2*i+1] + node[2*i+2];
      end
      return node[0];
   endfunction

   always_comb begin
      for (int i = 0; i < SIMD; i++) begin
         act_e[i] = act_data[i*TSRC_I +: TSRC_I];
         wgt_e[i] = wgt_tile[i*TW +: TW];
      end
   end

   // Product stage
   always_ff @(posedge clk) begin
      for (int i = 0; i < SIMD; i++) begin
         prod_q[i] <= acc_t'(act_e[i]) * acc_t'(wgt_e[i]);  // Signed, full width
      end
   end

   assign tile_sum = tree_sum(prod_q);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q   <= 1'b0;
         first_q   <= 1'b0;
         last_q    <= 1'b0;
         acc_valid <= 1'b0;
      end else begin
         valid_q   <= tile_valid;         // Flags ride with products
         first_q   <= tile_first;
         last_q    <= tile_last;
         acc_valid <= valid_q && last_q;
      end
   end

   // Accumulator, holds through input gaps
   always_ff @(posedge clk) begin
      if (valid_q) begin
         acc <= (first_q ? acc_t'(0) : acc) + tile_sum;  // Restart on new row
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mvau_out_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// Clips lane sums to res_t and registers the output word
module mvau_out_stage
   import mvau_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  acc_t      acc [PE],           // Lane accumulators
   input  logic      acc_valid,          // Lane 0 valid, lanes in lockstep
   output logic      out_valid,          // One-cycle pulse per pass
   output out_word_t out_data
);

   out_word_t clip_word;                 // Packed clipped results

   // Saturate to the signed result range
   function automatic res_t clip(input acc_t a);
      if (a > RES_MAX) begin
         return res_t'(RES_MAX);
      end else if (a < RES_MIN) begin
         return res_t'(RES_MIN);
      end
      return res_t'(a);                  // In range, keep low bits
   endfunction

   always_comb begin
      for (int p = 0; p < PE; p++) begin
         clip_word[p*TDST_I +: TDST_I] = clip(acc[p]);  // Lane p to slice p
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= acc_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (acc_valid) begin
         out_data <= clip_word;          // Held until next pass
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mvau.sv ====
`timescale 1ns/1ps
`default_nettype none

// Matrix-vector unit top
// SF input words per vector, NF passes give MATRIX_H clipped results.
module mvau
   import mvau_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       in_valid,          // Input word strobe
   input  in_word_t   in_data,
   input  logic       wgt_wen,           // Weight load strobe
   input  pe_idx_t    wgt_pe,
   input  tile_addr_t wgt_addr,
   input  wgt_tile_t  wgt_data,
   output logic       out_valid,         // PE results of one pass
   output out_word_t  out_data,
   output logic       busy               // Vector in progress
);

   logic       buf_wen;
   logic       buf_ren;
   sf_cnt_t    buf_addr;
   in_word_t   buf_data;                 // Replayed word
   tile_addr_t tile_addr;
   in_word_t   act_data;                 // Shared by all lanes
   logic       tile_valid;
   logic       tile_first;
   logic       tile_last;
   wgt_tile_t  lane_wgt [PE];            // Per-lane weight tiles
   acc_t       lane_acc [PE];
   logic       lane_valid [PE];

   mvau_control u_control (
      .clk,
      .arst_n,
      .in_valid,
      .in_data,
      .buf_wen,
      .buf_ren,
      .buf_addr,
      .buf_data,
      .tile_addr,
      .act_data,
      .tile_valid,
      .tile_first,
      .tile_last,
      .busy
   );

   mvau_inp_buffer u_inp_buffer (
      .clk,
      .wen   (buf_wen),
      .ren   (buf_ren),
      .addr  (buf_addr),
      .wdata (in_data),
      .rdata (buf_data)
   );

   mvau_weight_mem u_weight_mem (
      .clk,
      .wgt_wen,
      .wgt_pe,
      .wgt_addr,
      .wgt_data,
      .tile_addr,
      .wgt_tile (lane_wgt)
   );

   for (genvar p = 0; p < PE; p++) begin : pe_lane
      mvau_pe u_pe (
         .clk,
         .arst_n,
         .tile_valid,
         .tile_first,
         .tile_last,
         .act_data,
         .wgt_tile  (lane_wgt[p]),
         .acc       (lane_acc[p]),
         .acc_valid (lane_valid[p])
      );
   end

   mvau_out_stage u_out_stage (
      .clk,
      .arst_n,
      .acc       (lane_acc),
      .acc_valid (lane_valid[0]),        // Lanes share timing
      .out_valid,
      .out_data
   );

endmodule

`default_nettype wire

// ==== tb/mvau_model.svh ====
`ifndef MVAU_MODEL_SVH
`define MVAU_MODEL_SVH

wgt_t      w_model [MATRIX_H][MATRIX_W];   // Weights, row major
act_t      v_model [MATRIX_W];             // Vector being sent
out_word_t exp_q [$];                      // Expected words, row order
int        err_cnt = 0;
int        chk_cnt = 0;

// Saturate a full precision sum to the result range
function automatic res_t clip_model(input int s);
   int hi;
   int lo;
   hi = (1 << (TDST_I - 1)) - 1;
   lo = -(1 << (TDST_I - 1));
   if (s > hi) begin
      s = hi;
   end else if (s < lo) begin
      s = lo;
   end
   return res_t'(s);
endfunction

// Push the NF words for v_model, PE rows per word
function automatic void model_vector();
   int        sum;
   out_word_t word;
   for (int nf = 0; nf < NF; nf++) begin
      word = '0;
      for (int p = 0; p < PE; p++) begin
         sum = 0;
         for (int c = 0; c < MATRIX_W; c++) begin
            sum += int'(w_model[nf*PE+p][c]) * int'(v_model[c]);  // Full precision
         end
         word[p*TDST_I +: TDST_I] = clip_model(sum);              // Lane p in slice p
      end
      exp_q.push_back(word);
   end
endfunction

task automatic check_word(input string name, input out_word_t got, input out_word_t exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
   end
endtask

task automatic check_busy(input logic got, input logic exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error: busy got %h expected %h at %0t", got, exp, $time);
   end
endtask

`endif

// ==== tb/mvau_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mvau_tb
   import mvau_pkg::*;
();

   localparam int T_CLK    = 100;        // ns
   localparam int T_DRV    = 1;          // Drive delay after rising edge
   localparam int WAIT_MAX = 200;        // Cycles allowed per wait

   logic       clk;
   logic       arst_n;
   logic       in_valid;
   in_word_t   in_data;
   logic       wgt_wen;
   pe_idx_t    wgt_pe;
   tile_addr_t wgt_addr;
   wgt_tile_t  wgt_data;
   logic       out_valid;
   out_word_t  out_data;
   logic       busy;

   int   seed = 32'h0161_667d;
   int   cyc = 0;                        // Rising edges seen
   int   last_in_cyc = 0;                // Cycle of last in_valid of a vector
   logic lat_pending = 1'b0;             // First out_valid of a vector still due
   int   test_err = 0;

   `include "mvau_model.svh"

   mvau dut (
      .clk,
      .arst_n,
      .in_valid,
      .in_data,
      .wgt_wen,
      .wgt_pe,
      .wgt_addr,
      .wgt_data,
      .out_valid,
      .out_data,
      .busy
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(T_CLK / 2) clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // Output monitor, samples mid cycle
   always @(negedge clk) begin
      if (arst_n && out_valid) begin
         if (exp_q.size() == 0) begin
            err_cnt++;
            $display("out_valid pulsed with no result expected at %0t", $time);
         end else begin
            check_word("out_data", out_data, exp_q.pop_front());
         end
         if (lat_pending) begin
            lat_pending = 1'b0;
            if (cyc != last_in_cyc + 4) begin   // Four cycles after last tile
               err_cnt++;
               $display("first out_valid came in cycle %0d instead of cycle %0d",
                        cyc, last_in_cyc + 4);
            end
         end
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #T_DRV;
   endtask

   // Write all tiles of lane p from w_model
   task automatic load_lane(input int p);
      for (int nf = 0; nf < NF; nf++) begin
         for (int sf = 0; sf < SF; sf++) begin
            wgt_wen  = 1'b1;
            wgt_pe   = pe_idx_t'(p);
            wgt_addr = tile_addr_t'(nf * SF + sf);
            for (int i = 0; i < SIMD; i++) begin
               wgt_data[i*TW +: TW] = w_model[nf*PE+p][sf*SIMD+i];
            end
            next_cycle();
         end
      end
      wgt_wen = 1'b0;
   endtask

   task automatic set_weights(input logic rnd, input wgt_t k);
      for (int r = 0; r < MATRIX_H; r++) begin
         for (int c = 0; c < MATRIX_W; c++) begin
            w_model[r][c] = rnd ? wgt_t'($random(seed)) : k;
         end
      end
      for (int p = 0; p < PE; p++) begin
         load_lane(p);
      end
   endtask

   function automatic void set_vector(input logic rnd, input act_t k);
      for (int c = 0; c < MATRIX_W; c++) begin
         v_model[c] = rnd ? act_t'($random(seed)) : k;
      end
   endfunction

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy && n < WAIT_MAX) begin
         next_cycle();
         n++;
      end
      if (busy) begin
         err_cnt++;
         $display("timeout, busy stayed high for %0d cycles", WAIT_MAX);
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < WAIT_MAX) begin
         next_cycle();
         n++;
      end
      if (exp_q.size() != 0) begin
         err_cnt++;
         $display("timeout, %0d results never came out", exp_q.size());
         exp_q.delete();
      end
   endtask

   // SF strobes of v_model, up to gap_max idle cycles between them
   task automatic send_vector(input int gap_max);
      int gap;
      wait_idle();
      model_vector();
      for (int sf = 0; sf < SF; sf++) begin
         for (int i = 0; i < SIMD; i++) begin
            in_data[i*TSRC_I +: TSRC_I] = v_model[sf*SIMD+i];
         end
         in_valid    = 1'b1;
         last_in_cyc = cyc;
         next_cycle();
         in_valid = 1'b0;
         if (sf == 0) begin
            check_busy(busy, 1'b1);      // Up with the first word
         end
         if (sf < SF - 1 && gap_max > 0) begin
            gap = int'($unsigned($random(seed)) % (gap_max + 1));
            repeat (gap) next_cycle();
         end
      end
      lat_pending = 1'b1;
   endtask

   task automatic report_test(input string name);
      $display("%s: %0d errors", name, err_cnt - test_err);
      test_err = err_cnt;
   endtask

   initial begin
      arst_n   = 1'b0;
      in_valid = 1'b0;
      in_data  = '0;
      wgt_wen  = 1'b0;
      wgt_pe   = '0;
      wgt_addr = '0;
      wgt_data = '0;
      repeat (5) @(posedge clk);
      #T_DRV;
      arst_n = 1'b1;

      if (out_valid !== 1'b0) begin
         err_cnt++;
         $display("** Error: out_valid got %h expected 0 after reset", out_valid);
      end
      check_busy(busy, 1'b0);
      set_weights(1'b1, '0);
      set_vector(1'b0, '0);
      send_vector(0);
      wait_drain();
      report_test("test 1 reset and zero vector");

      for (int v = 0; v < 6; v++) begin
         set_vector(1'b1, '0);
         send_vector(0);                 // Back-to-back words
      end
      wait_drain();
      report_test("test 2 back-to-back vectors");

      set_weights(1'b1, '0);
      for (int v = 0; v < 6; v++) begin
         set_vector(1'b1, '0);
         send_vector(3);
      end
      wait_drain();
      report_test("test 3 vectors with gaps");

      set_weights(1'b0, wgt_t'(7));      // Max weights
      set_vector(1'b0, act_t'(7));
      send_vector(0);                    // Positive saturation
      set_vector(1'b0, act_t'(-8));
      send_vector(0);                    // Negative saturation
      wait_drain();
      set_weights(1'b0, wgt_t'(-8));
      send_vector(1);                    // Min times min
      wait_drain();
      report_test("test 4 saturation");

      set_weights(1'b1, '0);
      set_vector(1'b1, '0);
      send_vector(2);
      wait_drain();
      check_busy(busy, 1'b0);
      for (int nf = 0; nf < NF; nf++) begin
         for (int c = 0; c < MATRIX_W; c++) begin
            w_model[nf*PE+PE-1][c] = wgt_t'($random(seed));  // Last lane only
         end
      end
      load_lane(PE - 1);
      send_vector(0);                    // Same vector, new lane weights
      wait_drain();
      report_test("test 5 busy and lane reload");

      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tb
rtl/mvau_pkg.sv
rtl/mvau_inp_buffer.sv
rtl/mvau_control.sv
rtl/mvau_weight_mem.sv
rtl/mvau_pe.sv
rtl/mvau_out_stage.sv
rtl/mvau.sv
tb/mvau_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the mvau testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module mvau_tb -o mvau_sim \
   || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/mvau_sim)"
echo "$sim_out"

echo "$sim_out" | grep -qx "TEST PASS" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
